// ==== list.f ====
+incdir+common
+incdir+test
common/axi_upsizer_pkg.sv
hw/skid_buf.sv
axi_upsizer/axi_upsizer_ctrl.sv
axi_upsizer/axi_upsizer_pack.sv
axi_upsizer/axi_upsizer_top.sv
test/tb_axi_upsizer.sv

// ==== run.sh ====
#!/bin/sh
# build the axi upsizer testbench with verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_axi_upsizer \
    -f list.f -o tb_axi_upsizer --Mdir obj_dir
./obj_dir/tb_axi_upsizer > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log

// ==== test/tb_axi_upsizer_model.svh ====
// axi upsizer reference model: expected master aw and wide beats of one slave burst
`ifndef TB_AXI_UPSIZER_MODEL_SVH
`define TB_AXI_UPSIZER_MODEL_SVH

    // slave beats of the current burst
    s_data_t beat_data [16];
    s_strb_t beat_strb [16];

    len_t  exp_awlen;
    size_t exp_awsize;

    // expected wide beats in order
    m_data_t exp_data_q [$];
    m_strb_t exp_strb_q [$];
    logic    exp_last_q [$];
    // data lanes that hold slave data in each expected beat
    m_data_t exp_mask_q [$];

    task automatic push_beat(input m_data_t data, input m_strb_t strb, input m_data_t mask,
                             input logic last);
        exp_data_q.push_back(data);
        exp_strb_q.push_back(strb);
        exp_mask_q.push_back(mask);
        exp_last_q.push_back(last);
    endtask

    task automatic build_expected(input addr_t addr, input len_t len, input size_t size,
                                  input cache_t cache);
        logic    merge_burst;
        addr_t   a;
        addr_t   a_next;
        seg_t    s;
        m_data_t acc_data;
        m_data_t acc_mask;
        m_strb_t acc_strb;
        int      i;

        merge_burst = (`AXI_UP_CONVERT_BURST != 0) && cache[1] && (size == `AXI_UP_S_SIZE);
        if (merge_burst) begin
            // one wide beat per 16-byte word that the burst touches
            exp_awlen = len_t'((int'(len) + int'(addr[3:2])) / 4);
            exp_awsize = size_t'(`AXI_UP_M_SIZE);
        end else begin
            exp_awlen = len;
            exp_awsize = size;
        end
        exp_data_q.delete();
        exp_strb_q.delete();
        exp_mask_q.delete();
        exp_last_q.delete();
        a = addr;
        acc_data = '0;
        acc_mask = '0;
        acc_strb = '0;
        for (i = 0; i <= int'(len); i++) begin
            s = a[3:2];
            a_next = a + (addr_t'(1) << size);
            if (merge_burst) begin
                acc_data[s*32 +: 32] = beat_data[i];
                acc_mask[s*32 +: 32] = 32'hffff_ffff;
                acc_strb[s*4 +: 4] = beat_strb[i];
                // wide word is done once the next address leaves it
                if (a_next[4] != a[4] || i == int'(len)) begin
                    push_beat(acc_data, acc_strb, acc_mask, i == int'(len));
                    acc_data = '0;
                    acc_mask = '0;
                    acc_strb = '0;
                end
            end else begin
                acc_strb = '0;
                acc_strb[s*4 +: 4] = beat_strb[i];
                push_beat({4{beat_data[i]}}, acc_strb, {128{1'b1}}, i == int'(len));
            end
            a = a_next;
        end
    endtask

`endif

// ==== test/tb_axi_upsizer.sv ====
// axi upsizer testbench with random bursts, a master-side responder and reference model checks
`include "axi_upsizer_cfg.svh"

module tb_axi_upsizer
    import axi_upsizer_pkg::*;
();

    localparam logic [15:0] seed = 16'd33;
    localparam int burst_count = 200;
    localparam int timeout_cycles = burst_count * 16 * 8;

    logic    clk;
    logic    rst;

    id_t     s_awid;
    addr_t   s_awaddr;
    len_t    s_awlen;
    size_t   s_awsize;
    burst_t  s_awburst;
    cache_t  s_awcache;
    prot_t   s_awprot;
    logic    s_awvalid;
    logic    s_awready;
    s_data_t s_wdata;
    s_strb_t s_wstrb;
    logic    s_wlast;
    logic    s_wvalid;
    logic    s_wready;
    id_t     s_bid;
    resp_t   s_bresp;
    logic    s_bvalid;
    logic    s_bready;

    addr_t   m_awaddr;
    len_t    m_awlen;
    size_t   m_awsize;
    burst_t  m_awburst;
    cache_t  m_awcache;
    prot_t   m_awprot;
    logic    m_awvalid;
    logic    m_awready;
    m_data_t m_wdata;
    m_strb_t m_wstrb;
    logic    m_wlast;
    logic    m_wvalid;
    logic    m_wready;
    resp_t   m_bresp;
    logic    m_bvalid;
    logic    m_bready;

    logic [15:0] lfsr;
    int cycles, started, finished, w_idx, n_beats;
    logic in_flight, aw_seen, w_done, m_b_done;
    logic s_aw_fire, s_w_fire, m_b_fire;

    // current burst
    id_t    cur_id;
    addr_t  cur_addr;
    len_t   cur_len;
    size_t  cur_size;
    cache_t cur_cache;
    prot_t  cur_prot;
    resp_t  exp_bresp;

    `include "tb_axi_upsizer_model.svh"

    axi_upsizer_top i_axi_upsizer_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;

        r = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_idle_outputs(input string phase);
        check_value({phase, " s_awready"}, 0, s_awready);
        check_value({phase, " s_wready"}, 0, s_wready);
        check_value({phase, " s_bvalid"}, 0, s_bvalid);
        check_value({phase, " m_awvalid"}, 0, m_awvalid);
        check_value({phase, " m_wvalid"}, 0, m_wvalid);
        check_value({phase, " m_bready"}, 0, m_bready);
    endtask

    task automatic start_burst();
        addr_t   a;
        s_strb_t lanes;
        int      i;

        cur_id = id_t'(rand_bits(4));
        cur_len = len_t'(rand_bits(4));
        cur_size = size_t'(rand_bits(2) % 3);
        cur_cache = cache_t'(rand_bits(4));
        cur_prot = prot_t'(rand_bits(3));
        cur_addr = addr_t'(rand_bits(32));
        cur_addr = cur_addr & ~((addr_t'(1) << cur_size) - addr_t'(1));
        // lower half of a 4 kB page keeps a burst of at most 64 bytes inside it
        cur_addr[11] = 1'b0;
        a = cur_addr;
        for (i = 0; i <= int'(cur_len); i++) begin
            case (cur_size)
                3'd0: lanes = 4'b0001 << a[1:0];
                3'd1: lanes = 4'b0011 << {a[1], 1'b0};
                default: lanes = 4'b1111;
            endcase
            beat_data[i] = s_data_t'(rand_bits(32));
            beat_strb[i] = s_strb_t'(rand_bits(4)) & lanes;
            a = a + (addr_t'(1) << cur_size);
        end
        build_expected(cur_addr, cur_len, cur_size, cur_cache);
        s_awid <= cur_id;
        s_awaddr <= cur_addr;
        s_awlen <= cur_len;
        s_awsize <= cur_size;
        s_awburst <= 2'b01;
        s_awcache <= cur_cache;
        s_awprot <= cur_prot;
        s_awvalid <= 1'b1;
        n_beats = int'(cur_len) + 1;
        w_idx = 0;
        in_flight = 1'b1;
        aw_seen = 1'b0;
        w_done = 1'b0;
        m_b_done = 1'b0;
        started++;
    endtask

    task automatic drive_channels();
        if (s_aw_fire) begin
            s_awvalid <= 1'b0;
        end
        if (s_w_fire) begin
            w_idx++;
        end
        if (!in_flight && started < burst_count) begin
            start_burst();
        end
        // a presented beat stays until it is taken
        if (!s_wvalid || s_w_fire) begin
            if (in_flight && w_idx < n_beats) begin
                s_wvalid <= rand_bits(2) != 0;
                s_wdata <= beat_data[w_idx];
                s_wstrb <= beat_strb[w_idx];
                s_wlast <= w_idx == n_beats - 1;
            end else begin
                s_wvalid <= 1'b0;
            end
        end
        m_awready <= rand_bits(2) != 0;
        m_wready <= rand_bits(2) != 0;
        s_bready <= rand_bits(2) != 0;
        // master response only after its aw and last wide beat
        if (m_b_fire) begin
            m_bvalid <= 1'b0;
        end else if (!m_bvalid && !m_b_done && aw_seen && w_done) begin
            if (rand_bits(1) == 1) begin
                exp_bresp = resp_t'(rand_bits(2));
                m_bresp <= exp_bresp;
                m_bvalid <= 1'b1;
            end
        end
    endtask

    task automatic observe_channels();
        s_aw_fire = s_awvalid && s_awready;
        s_w_fire = s_wvalid && s_wready;
        m_b_fire = m_bvalid && m_bready;
        if (m_awvalid && m_awready) begin
            if (aw_seen) begin
                $display("a second master AW appeared for one burst");
                stop_on_error();
            end
            aw_seen = 1'b1;
            check_value("m_awaddr", cur_addr, m_awaddr);
            check_value("m_awlen", exp_awlen, m_awlen);
            check_value("m_awsize", exp_awsize, m_awsize);
            check_value("m_awburst", 2'b01, m_awburst);
            check_value("m_awcache", cur_cache, m_awcache);
            check_value("m_awprot", cur_prot, m_awprot);
        end
        if (m_wvalid && m_wready) begin
            if (exp_data_q.size() == 0) begin
                $display("a master W beat arrived when none was expected");
                stop_on_error();
            end
            check_value("m_wdata", exp_data_q[0] & exp_mask_q[0], m_wdata & exp_mask_q[0]);
            check_value("m_wstrb", exp_strb_q[0], m_wstrb);
            check_value("m_wlast", exp_last_q[0], m_wlast);
            w_done = exp_last_q[0];
            void'(exp_data_q.pop_front());
            void'(exp_strb_q.pop_front());
            void'(exp_mask_q.pop_front());
            void'(exp_last_q.pop_front());
        end
        if (m_b_fire) begin
            m_b_done = 1'b1;
        end
        if (s_bvalid && s_bready) begin
            if (!in_flight || !m_b_done) begin
                $display("a slave B response came before the master response");
                stop_on_error();
            end
            check_value("s_bid", cur_id, s_bid);
            check_value("s_bresp", exp_bresp, s_bresp);
            in_flight = 1'b0;
            finished++;
        end
    endtask

    initial begin
        lfsr = seed;
        cycles = 0;
        started = 0;
        finished = 0;
        w_idx = 0;
        n_beats = 0;
        in_flight = 1'b0;
        aw_seen = 1'b0;
        w_done = 1'b0;
        m_b_done = 1'b0;
        s_aw_fire = 1'b0;
        s_w_fire = 1'b0;
        m_b_fire = 1'b0;
        exp_bresp = '0;
        rst = 1'b1;
        s_awid = '0;
        s_awaddr = '0;
        s_awlen = '0;
        s_awsize = '0;
        s_awburst = '0;
        s_awcache = '0;
        s_awprot = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_wlast = 1'b0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        m_awready = 1'b0;
        m_wready = 1'b0;
        m_bresp = '0;
        m_bvalid = 1'b0;

        repeat (7) begin
            @(posedge clk);
            @(negedge clk);
            check_idle_outputs("reset");
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle_outputs("after reset");

        // drive on the rising edge and sample on the falling edge
        while (finished < burst_count) begin
            @(posedge clk);
            drive_channels();
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout after %0d cycles with %0d bursts done", cycles, finished);
                stop_on_error();
            end
            observe_channels();
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== axi_upsizer/axi_upsizer_top.sv ====
// axi upsizer top: 32-bit axi4 write slave to 128-bit axi4 write master
`include "axi_upsizer_cfg.svh"

module axi_upsizer_top
    import axi_upsizer_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  id_t     s_awid,
    input  addr_t   s_awaddr,
    input  len_t    s_awlen,
    input  size_t   s_awsize,
    input  burst_t  s_awburst,
    input  cache_t  s_awcache,
    input  prot_t   s_awprot,
    input  logic    s_awvalid,
    output logic    s_awready,
    input  s_data_t s_wdata,
    input  s_strb_t s_wstrb,
    input  logic    s_wlast,
    input  logic    s_wvalid,
    output logic    s_wready,
    output id_t     s_bid,
    output resp_t   s_bresp,
    output logic    s_bvalid,
    input  logic    s_bready,

    output addr_t   m_awaddr,
    output len_t    m_awlen,
    output size_t   m_awsize,
    output burst_t  m_awburst,
    output cache_t  m_awcache,
    output prot_t   m_awprot,
    output logic    m_awvalid,
    input  logic    m_awready,
    output m_data_t m_wdata,
    output m_strb_t m_wstrb,
    output logic    m_wlast,
    output logic    m_wvalid,
    input  logic    m_wready,
    input  resp_t   m_bresp,
    input  logic    m_bvalid,
    output logic    m_bready
);

    // wide data, strobe and last in one payload
    localparam int buf_w = `AXI_UP_M_DATA_W + `AXI_UP_M_STRB_W + 1;

    logic    beat_en;
    logic    merge;
    seg_t    seg;
    logic    buf_last;
    logic    buf_valid;
    logic    ready_early;
    m_data_t pack_data;
    m_strb_t pack_strb;

    logic [buf_w-1:0] buf_in;
    logic [buf_w-1:0] buf_out;

    axi_upsizer_ctrl i_axi_upsizer_ctrl (.*);

    axi_upsizer_pack i_axi_upsizer_pack (
        .clk       (clk),
        .beat_en   (beat_en),
        .merge     (merge),
        .flush     (buf_valid),
        .seg       (seg),
        .wdata     (s_wdata),
        .wstrb     (s_wstrb),
        .pack_data (pack_data),
        .pack_strb (pack_strb)
    );

    assign buf_in = {pack_data, pack_strb, buf_last};

    skid_buf #(
        .WIDTH (buf_w)
    ) i_skid_buf (
        .clk         (clk),
        .rst         (rst),
        .in_payload  (buf_in),
        .in_valid    (buf_valid),
        .ready_early (ready_early),
        .out_payload (buf_out),
        .out_valid   (m_wvalid),
        .out_ready   (m_wready)
    );

    assign m_wdata = buf_out[buf_w-1 -: `AXI_UP_M_DATA_W];
    assign m_wstrb = buf_out[`AXI_UP_M_STRB_W:1];
    assign m_wlast = buf_out[0];

endmodule

// ==== axi_upsizer/axi_upsizer_pack.sv ====
// axi upsizer packer: accumulates merged wide beats and steers narrow beats to their lanes
`include "axi_upsizer_cfg.svh"

module axi_upsizer_pack
    import axi_upsizer_pkg::*;
(
    input  logic    clk,
    input  logic    beat_en,
    input  logic    merge,
    input  logic    flush,
    input  seg_t    seg,
    input  s_data_t wdata,
    input  s_strb_t wstrb,
    output m_data_t pack_data,
    output m_strb_t pack_strb
);

    m_data_t data_reg;
    m_strb_t strb_reg;

    m_data_t data_merged;
    m_strb_t strb_merged;
    m_strb_t strb_narrow;

    // current beat laid over the accumulated wide word
    always_comb begin
        data_merged = data_reg;
        strb_merged = strb_reg;
        data_merged[seg*`AXI_UP_S_DATA_W +: `AXI_UP_S_DATA_W] = wdata;
        strb_merged[seg*`AXI_UP_S_STRB_W +: `AXI_UP_S_STRB_W] = wstrb;
    end

    // narrow beats keep only the strobe of the addressed segment
    always_comb begin
        strb_narrow = '0;
        strb_narrow[seg*`AXI_UP_S_STRB_W +: `AXI_UP_S_STRB_W] = wstrb;
    end

    always_ff @(posedge clk) begin
        if (!merge) begin
            // accumulator starts empty for every merged burst
            strb_reg <= '0;
        end else if (beat_en) begin
            data_reg <= data_merged;
            strb_reg <= flush ? '0 : strb_merged;
        end
    end

    always_comb begin
        if (merge) begin
            pack_data = data_merged;
            pack_strb = strb_merged;
        end else begin
            pack_data = {`AXI_UP_SEG_COUNT{wdata}};
            pack_strb = strb_narrow;
        end
    end

endmodule

// ==== axi_upsizer/axi_upsizer_ctrl.sv ====
// axi upsizer controller: burst fsm, aw translation, address tracking and b return
`include "axi_upsizer_cfg.svh"

module axi_upsizer_ctrl
    import axi_upsizer_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  id_t    s_awid,
    input  addr_t  s_awaddr,
    input  len_t   s_awlen,
    input  size_t  s_awsize,
    input  burst_t s_awburst,
    input  cache_t s_awcache,
    input  prot_t  s_awprot,
    input  logic   s_awvalid,
    output logic   s_awready,

    input  logic   s_wlast,
    input  logic   s_wvalid,
    output logic   s_wready,

    output id_t    s_bid,
    output resp_t  s_bresp,
    output logic   s_bvalid,
    input  logic   s_bready,

    output addr_t  m_awaddr,
    output len_t   m_awlen,
    output size_t  m_awsize,
    output burst_t m_awburst,
    output cache_t m_awcache,
    output prot_t  m_awprot,
    output logic   m_awvalid,
    input  logic   m_awready,

    input  resp_t  m_bresp,
    input  logic   m_bvalid,
    output logic   m_bready,

    output logic   beat_en,
    output logic   merge,
    output seg_t   seg,
    output logic   buf_last,
    output logic   buf_valid,
    input  logic   ready_early
);

    localparam int seg_shift = $clog2(`AXI_UP_SEG_COUNT);

    ctrl_state_t state_reg, state_next;

    logic s_awready_reg, s_awready_next;
    logic s_wready_reg, s_wready_next;
    logic s_bvalid_reg, s_bvalid_next;
    logic m_awvalid_reg, m_awvalid_next;
    logic m_bready_reg, m_bready_next;

    id_t   id_reg;
    addr_t addr_reg;
    len_t  burst_reg;
    size_t size_reg;
    id_t   s_bid_reg;
    resp_t s_bresp_reg;

    addr_t  m_awaddr_reg;
    len_t   m_awlen_reg;
    size_t  m_awsize_reg;
    burst_t m_awburst_reg;
    cache_t m_awcache_reg;
    prot_t  m_awprot_reg;

    logic  aw_fire;
    logic  b_fire;
    logic  aw_merge;
    len_t  merge_len;
    addr_t addr_inc;
    logic  wide_cross;

    assign aw_fire = s_awready_reg && s_awvalid;
    assign b_fire = m_bready_reg && m_bvalid;
    assign beat_en = s_wready_reg && s_wvalid;

    // full-size modifiable bursts are merged into wide beats
    assign aw_merge = (`AXI_UP_CONVERT_BURST != 0) && s_awcache[1]
        && (s_awsize == size_t'(`AXI_UP_S_SIZE));
    assign merge_len = (s_awlen + len_t'(s_awaddr[`AXI_UP_M_SIZE-1:`AXI_UP_S_SIZE]))
        >> seg_shift;

    assign addr_inc = addr_reg + (addr_t'(1) << size_reg);
    assign wide_cross = addr_inc[`AXI_UP_M_SIZE] != addr_reg[`AXI_UP_M_SIZE];

    assign seg = addr_reg[`AXI_UP_M_SIZE-1:`AXI_UP_S_SIZE];
    assign merge = state_reg == st_merge;
    assign buf_last = s_wlast;

    // a merged wide beat leaves when the next address starts a new wide word
    always_comb begin
        case (state_reg)
            st_pass:  buf_valid = beat_en;
            st_merge: buf_valid = beat_en && (wide_cross || burst_reg == '0);
            default:  buf_valid = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state_reg;
        s_awready_next = 1'b0;
        s_wready_next = 1'b0;
        s_bvalid_next = s_bvalid_reg && !s_bready;
        m_awvalid_next = m_awvalid_reg && !m_awready;
        m_bready_next = 1'b0;

        case (state_reg)
            st_idle: begin
                s_awready_next = !m_awvalid_reg;
                if (aw_fire) begin
                    s_awready_next = 1'b0;
                    s_wready_next = ready_early;
                    m_awvalid_next = 1'b1;
                    state_next = aw_merge ? st_merge : st_pass;
                end
            end
            st_pass: begin
                s_wready_next = ready_early;
                if (beat_en && s_wlast) begin
                    s_wready_next = 1'b0;
                    m_bready_next = !s_bvalid_reg;
                    state_next = st_resp;
                end
            end
            st_merge: begin
                s_wready_next = ready_early;
                if (beat_en && burst_reg == '0) begin
                    s_wready_next = 1'b0;
                    m_bready_next = !s_bvalid_reg;
                    state_next = st_resp;
                end
            end
            default: begin
                m_bready_next = !s_bvalid_reg;
                if (b_fire) begin
                    m_bready_next = 1'b0;
                    s_bvalid_next = 1'b1;
                    s_awready_next = !m_awvalid_reg;
                    state_next = st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= st_idle;
            s_awready_reg <= 1'b0;
            s_wready_reg <= 1'b0;
            s_bvalid_reg <= 1'b0;
            m_awvalid_reg <= 1'b0;
            m_bready_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            s_awready_reg <= s_awready_next;
            s_wready_reg <= s_wready_next;
            s_bvalid_reg <= s_bvalid_next;
            m_awvalid_reg <= m_awvalid_next;
            m_bready_reg <= m_bready_next;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_reg <= s_awid;
            addr_reg <= s_awaddr;
            burst_reg <= s_awlen;
            size_reg <= s_awsize;
            m_awaddr_reg <= s_awaddr;
            m_awlen_reg <= aw_merge ? merge_len : s_awlen;
            m_awsize_reg <= aw_merge ? size_t'(`AXI_UP_M_SIZE) : s_awsize;
            m_awburst_reg <= s_awburst;
            m_awcache_reg <= s_awcache;
            m_awprot_reg <= s_awprot;
        end else if (beat_en) begin
            addr_reg <= addr_inc;
            burst_reg <= burst_reg - 1'b1;
        end

        if (b_fire) begin
            s_bid_reg <= id_reg;
            s_bresp_reg <= m_bresp;
        end
    end

    assign s_awready = s_awready_reg;
    assign s_wready = s_wready_reg;
    assign s_bid = s_bid_reg;
    assign s_bresp = s_bresp_reg;
    assign s_bvalid = s_bvalid_reg;

    assign m_awaddr = m_awaddr_reg;
    assign m_awlen = m_awlen_reg;
    assign m_awsize = m_awsize_reg;
    assign m_awburst = m_awburst_reg;
    assign m_awcache = m_awcache_reg;
    assign m_awprot = m_awprot_reg;
    assign m_awvalid = m_awvalid_reg;
    assign m_bready = m_bready_reg;

endmodule

// ==== hw/skid_buf.sv ====
// skid buffer: output register with a temp register behind it and a registered input ready
module skid_buf #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,

    input  logic [WIDTH-1:0] in_payload,
    input  logic             in_valid,
    output logic             ready_early,

    output logic [WIDTH-1:0] out_payload,
    output logic             out_valid,
    input  logic             out_ready
);

    logic [WIDTH-1:0] out_reg;
    logic [WIDTH-1:0] temp_reg;

    logic in_ready_reg;
    logic out_valid_reg, out_valid_next;
    logic temp_valid_reg, temp_valid_next;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // ready next cycle unless the temp register could fill up
    assign ready_early = out_ready | (~temp_valid_reg & (~out_valid_reg | ~in_valid));

    always_comb begin
        out_valid_next = out_valid_reg;
        temp_valid_next = temp_valid_reg;
        store_in_to_out = 1'b0;
        store_in_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready_reg) begin
            if (out_ready | ~out_valid_reg) begin
                out_valid_next = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat in temp
                temp_valid_next = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = temp_valid_reg;
            temp_valid_next = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready_reg <= 1'b0;
            out_valid_reg <= 1'b0;
            temp_valid_reg <= 1'b0;
        end else begin
            in_ready_reg <= ready_early;
            out_valid_reg <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_reg <= in_payload;
        end else if (store_temp_to_out) begin
            out_reg <= temp_reg;
        end

        if (store_in_to_temp) begin
            temp_reg <= in_payload;
        end
    end

    assign out_payload = out_reg;
    assign out_valid = out_valid_reg;

endmodule

// ==== common/axi_upsizer_pkg.sv ====
// axi upsizer package with the vector types and the controller state encoding
`include "axi_upsizer_cfg.svh"

package axi_upsizer_pkg;

    typedef logic [`AXI_UP_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_UP_ID_W-1:0] id_t;

    // one word on each side of the adapter
    typedef logic [`AXI_UP_S_DATA_W-1:0] s_data_t;
    typedef logic [`AXI_UP_S_STRB_W-1:0] s_strb_t;
    typedef logic [`AXI_UP_M_DATA_W-1:0] m_data_t;
    typedef logic [`AXI_UP_M_STRB_W-1:0] m_strb_t;

    // aw attributes
    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;
    typedef logic [3:0] cache_t;
    typedef logic [2:0] prot_t;

    typedef logic [1:0] resp_t;

    // slave segment inside a wide beat
    typedef logic [$clog2(`AXI_UP_SEG_COUNT)-1:0] seg_t;

    typedef enum logic [1:0] {
        st_idle,
        st_pass,
        st_merge,
        st_resp
    } ctrl_state_t;

endpackage

// ==== common/axi_upsizer_cfg.svh ====
// axi upsizer configuration: bus widths, size codes and the burst merge switch
`ifndef AXI_UPSIZER_CFG_SVH
`define AXI_UPSIZER_CFG_SVH

// address and id
`define AXI_UP_ADDR_W 32
`define AXI_UP_ID_W 4

// 32-bit slave side, 128-bit master side
`define AXI_UP_S_DATA_W 32
`define AXI_UP_M_DATA_W 128
`define AXI_UP_S_STRB_W 4
`define AXI_UP_M_STRB_W 16
`define AXI_UP_SEG_COUNT 4

// axsize codes of the two buses
`define AXI_UP_S_SIZE 2
`define AXI_UP_M_SIZE 4

// merge full-size incr bursts into wide beats when awcache allows it
`define AXI_UP_CONVERT_BURST 1

`endif
